// ==== rvx_exec.f ====
rvx_pkg.sv
rvx_wb_regs.sv
rvx_alu_stage.sv
rvx_mul.sv
rvx_result_stage.sv
rvx_exec_top.sv
rvx_exec_clk.sv
rvx_exec_asserts.sv
rvx_exec_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := rvx_exec_tb
FILELIST   := rvx_exec.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== rvx_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvx_exec_tb;
    import rvx_pkg::*;

    localparam int mul_steps  = 64;
    localparam int ack_limit  = 200;   // longer than a full multiply
    localparam int poll_limit = 100;

    logic        clk;
    logic        reset;
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [63:0] dat_w;
    logic [63:0] dat_r;
    logic        ack;
    integer      seed;
    int          last_wait;   // extra cycles the last access waited for ack
    logic [63:0] rd;

    alu_op_t     full_ops[10] = '{op_add, op_sub, op_and, op_or, op_xor,
                                  op_sll, op_srl, op_sra, op_slt, op_sltu};
    alu_op_t     word_ops[5]  = '{op_add, op_sub, op_sll, op_srl, op_sra};
    alu_op_t     br_ops[6]    = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    logic [63:0] pair_a[4]    = '{64'h1234, 64'h10, 64'h2000, 64'hffff_ffff_ffff_fffb};
    logic [63:0] pair_b[4]    = '{64'h1234, 64'h2000, 64'h10, 64'h3};

    rvx_exec_clk rvx_exec_clk_i (.clk(clk), .reset(reset));

    rvx_exec_top #(.mul_steps(mul_steps)) rvx_exec_top_i (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    task automatic access_reg(input logic write, input logic [2:0] addr,
                              input logic [63:0] wdata, output logic [63:0] rdata);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = write;
        adr   = addr;
        dat_w = wdata;
        @(posedge clk);
        #1;
        while (!ack && n < ack_limit) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!ack) begin
            $display("no ack from the DUT for address %0d within %0d cycles", addr, ack_limit);
            $display("RESULT: FAIL");
            $fatal(1, "bus access timed out");
        end
        rdata     = dat_r;    // read data valid while ack is high
        last_wait = n;
        @(posedge clk);       // ack seen on this edge, strobe ends
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic check_word(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [63:0] extend(input ext_mode_t ext, input logic [63:0] v);
        case (ext)
            ext_sext32: return {{32{v[31]}}, v[31:0]};
            ext_zext32: return {32'h0, v[31:0]};
            ext_sext16: return {{48{v[15]}}, v[15:0]};
            default:    return v;
        endcase
    endfunction

    // reference model for the value, before extension
    function automatic logic [63:0] expected_value(input alu_op_t op, input logic word,
                                                   input logic [63:0] a, input logic [63:0] b);
        logic signed [63:0] sa;
        logic [63:0]        a_cut;
        logic [63:0]        sra64;
        logic [31:0]        sra32;
        logic [5:0]         sh;
        sa    = a;
        a_cut = word ? {32'h0, a[31:0]} : a;
        sh    = word ? {1'b0, b[4:0]} : b[5:0];
        sra32 = $signed(a[31:0]) >>> sh;
        sra64 = sa >>> sh;
        case (op)
            op_add:  return a_cut + b;
            op_sub:  return a_cut - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a_cut << sh;
            op_srl:  return a_cut >> sh;
            op_sra:  return word ? {{32{sra32[31]}}, sra32} : sra64;
            op_slt:  return {63'h0, $signed(a) < $signed(b)};
            op_sltu: return {63'h0, a < b};
            op_pass: return b;
            op_mul:  return a * b;
            default: return 64'h0;   // compares leave zero
        endcase
    endfunction

    function automatic logic branch_taken(input alu_op_t op, input logic [63:0] a,
                                          input logic [63:0] b);
        case (op)
            op_beq:  return a == b;
            op_bne:  return a != b;
            op_blt:  return $signed(a) < $signed(b);
            op_bge:  return $signed(a) >= $signed(b);
            op_bltu: return a < b;
            op_bgeu: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic send_cmd(input alu_op_t op, input logic word, input ext_mode_t ext,
                            input logic [63:0] a, input logic [63:0] b);
        access_reg(1'b1, reg_src1, a, rd);
        access_reg(1'b1, reg_src2, b, rd);
        access_reg(1'b1, reg_cmd, {56'h0, ext, word, op}, rd);
    endtask

    // poll status until done, then compare result and flag
    task automatic check_result(input alu_op_t op, input logic word, input ext_mode_t ext,
                                input logic [63:0] a, input logic [63:0] b);
        logic [63:0] status;
        logic [63:0] result;
        int          polls;
        status = '0;
        polls  = 0;
        while (!status[0] && polls < poll_limit) begin
            access_reg(1'b0, reg_status, '0, status);
            polls++;
        end
        if (!status[0]) begin
            $display("done bit never set for op %0d after %0d status reads", op, poll_limit);
            $display("RESULT: FAIL");
            $fatal(1, "status poll timed out");
        end
        access_reg(1'b0, reg_result, '0, result);
        check_word("result", result, extend(ext, expected_value(op, word, a, b)));
        check_word("status.flag", {63'h0, status[2]}, {63'h0, branch_taken(op, a, b)});
        check_word("status.busy", {63'h0, status[1]}, 64'h0);
    endtask

    task automatic run_cmd(input alu_op_t op, input logic word, input ext_mode_t ext,
                           input logic [63:0] a, input logic [63:0] b);
        send_cmd(op, word, ext, a, b);
        check_result(op, word, ext, a, b);
    endtask

    initial begin
        logic [63:0] a;
        logic [63:0] b;
        int          n;
        seed  = 32'hf5aac98a;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = 3'd0;
        dat_w = 64'h0;
        n     = 0;
        while (reset !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (reset !== 1'b0) begin
            $display("reset never released");
            $display("RESULT: FAIL");
            $fatal(1, "reset timeout");
        end

        access_reg(1'b0, reg_status, '0, rd);
        check_word("status after reset", rd, 64'h0);
        access_reg(1'b0, reg_result, '0, rd);
        check_word("result after reset", rd, 64'h0);

        foreach (full_ops[i]) begin
            repeat (3) begin
                a = {$random(seed), $random(seed)};
                b = {$random(seed), $random(seed)};
                run_cmd(full_ops[i], 1'b0, ext_none, a, b);
            end
        end
        foreach (word_ops[i]) begin
            repeat (3) begin
                a = {$random(seed), $random(seed)};
                b = {$random(seed), $random(seed)};
                run_cmd(word_ops[i], 1'b1, ext_none, a, b);
            end
        end

        // equal, less, greater and sign-differing pairs
        foreach (br_ops[i]) begin
            foreach (pair_a[j]) begin
                run_cmd(br_ops[i], 1'b0, ext_none, pair_a[j], pair_b[j]);
            end
        end

        for (int e = 0; e < 4; e++) begin
            run_cmd(op_pass, 1'b0, ext_mode_t'(e), 64'h0, 64'h0123_4567_89ab_c0de);
            run_cmd(op_pass, 1'b0, ext_mode_t'(e), 64'h0, 64'hfedc_ba98_7654_3210);
        end

        repeat (3) begin
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            run_cmd(op_mul, 1'b0, ext_none, a, b);
        end

        // second command lands while the multiply still runs
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        send_cmd(op_mul, 1'b0, ext_none, a, b);
        send_cmd(op_add, 1'b0, ext_none, b, a);
        assert (last_wait > 2) else begin
            $display("command write was not held off while the multiply was busy");
            $display("RESULT: FAIL");
            $fatal(1, "no back-pressure on command write");
        end
        check_result(op_add, 1'b0, ext_none, b, a);

        $display("RESULT: PASS");
        $finish;
    end
endmodule

`default_nettype wire

// ==== rvx_exec_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvx_exec_asserts (
    input logic clk,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic issue_valid,
    input logic busy,
    input logic res_done
);
    ack_in_cycle: assert property (@(posedge clk) disable iff (reset) ack |-> (cyc && stb))
        else $error("ack raised outside a bus cycle");

    // one ack per strobe
    ack_single: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack held high for two cycles");

    issue_idle: assert property (@(posedge clk) disable iff (reset) issue_valid |-> !busy)
        else $error("command issued while the pipeline was busy");

    busy_clear: assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> $past(res_done))
        else $error("busy dropped without res_done");
endmodule

bind rvx_wb_regs rvx_exec_asserts rvx_exec_asserts_i (
    .clk         (clk),
    .reset       (reset),
    .cyc         (cyc),
    .stb         (stb),
    .ack         (ack),
    .issue_valid (issue_valid),
    .busy        (busy),
    .res_done    (res_done)
);

`default_nettype wire

// ==== rvx_exec_clk.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvx_exec_clk (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    // held high over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
    end
endmodule

`default_nettype wire

// ==== rvx_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvx_exec_top #(
    parameter int mul_steps = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [2:0]               adr,
    input  logic [rvx_pkg::xlen-1:0] dat_w,
    output logic [rvx_pkg::xlen-1:0] dat_r,
    output logic                     ack
);
    import rvx_pkg::*;

    exec_cmd_t       issue_cmd;
    logic            issue_valid;
    logic            mul_start;
    logic [xlen-1:0] mul_a;
    logic [xlen-1:0] mul_b;
    logic            mul_done;
    logic [xlen-1:0] mul_product;
    stage_res_t      stage_res;      // execute to result stage
    logic [xlen-1:0] final_value;
    logic            final_flag;
    logic            res_done;

    rvx_wb_regs rvx_wb_regs_i (
        .clk         (clk),
        .reset       (reset),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_w       (dat_w),
        .dat_r       (dat_r),
        .ack         (ack),
        .res_done    (res_done),
        .final_value (final_value),
        .final_flag  (final_flag),
        .issue_cmd   (issue_cmd),
        .issue_valid (issue_valid)
    );

    rvx_alu_stage rvx_alu_stage_i (
        .clk         (clk),
        .reset       (reset),
        .issue_cmd   (issue_cmd),
        .issue_valid (issue_valid),
        .mul_done    (mul_done),
        .mul_product (mul_product),
        .mul_start   (mul_start),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .stage_out   (stage_res)
    );

    rvx_mul #(
        .mul_steps (mul_steps)
    ) rvx_mul_i (
        .clk     (clk),
        .reset   (reset),
        .start   (mul_start),
        .a       (mul_a),
        .b       (mul_b),
        .done    (mul_done),
        .product (mul_product)
    );

    rvx_result_stage rvx_result_stage_i (
        .clk         (clk),
        .reset       (reset),
        .stage_in    (stage_res),
        .final_value (final_value),
        .final_flag  (final_flag),
        .res_done    (res_done)
    );

endmodule

`default_nettype wire

// ==== rvx_result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvx_result_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  rvx_pkg::stage_res_t      stage_in,
    output logic [rvx_pkg::xlen-1:0] final_value,
    output logic                     final_flag,
    output logic                     res_done
);
    import rvx_pkg::*;

    logic [xlen-1:0] ext_value;
    logic [xlen-1:0] v;

    assign v = stage_in.value;

    always_comb begin
        case (stage_in.ext)
            ext_sext32: ext_value = {{(xlen-32){v[31]}}, v[31:0]};
            ext_zext32: ext_value = {{(xlen-32){1'b0}}, v[31:0]};
            ext_sext16: ext_value = {{(xlen-16){v[15]}}, v[15:0]};
            default:    ext_value = v;   // ext_none
        endcase
    end

    // result holds until the next valid input
    always_ff @(posedge clk) begin
        if (reset) begin
            final_value <= '0;
            final_flag  <= 1'b0;
            res_done    <= 1'b0;
        end else begin
            res_done <= stage_in.valid;
            if (stage_in.valid) begin
                final_value <= ext_value;
                final_flag  <= stage_in.flag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rvx_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvx_mul #(
    parameter int mul_steps = 64
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic [rvx_pkg::xlen-1:0] a,
    input  logic [rvx_pkg::xlen-1:0] b,
    output logic                     done,
    output logic [rvx_pkg::xlen-1:0] product
);
    import rvx_pkg::*;

    localparam int cnt_w = $clog2(mul_steps + 1);

    logic [xlen-1:0]  mcand;     // multiplicand, shifts left
    logic [xlen-1:0]  mplier;    // multiplier, low bit picks the add
    logic [xlen-1:0]  acc;       // partial product, low half only
    logic [cnt_w-1:0] cnt;       // steps still to go
    logic             running;

    // iteration counter and done pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done    <= 1'b0;
            cnt     <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                cnt     <= cnt_w'(mul_steps);
            end else if (running) begin
                cnt <= cnt - cnt_w'(1);
                if (cnt == cnt_w'(1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;   // last add lands on this edge
                end
            end
        end
    end

    // one shift-add step per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= '0;
            mcand  <= a;
            mplier <= b;
        end else if (running) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // low bits agree for signed and unsigned operands
    assign product = acc;

endmodule

`default_nettype wire

// ==== rvx_alu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvx_alu_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  rvx_pkg::exec_cmd_t       issue_cmd,
    input  logic                     issue_valid,
    input  logic                     mul_done,
    input  logic [rvx_pkg::xlen-1:0] mul_product,
    output logic                     mul_start,
    output logic [rvx_pkg::xlen-1:0] mul_a,
    output logic [rvx_pkg::xlen-1:0] mul_b,
    output rvx_pkg::stage_res_t      stage_out
);
    import rvx_pkg::*;

    logic [xlen-1:0] op1;        // operand 1 after the word cut
    logic [xlen-1:0] op1_sra;
    logic [5:0]      shamt;
    logic            lt_s;
    logic            lt_u;
    logic [xlen-1:0] alu_val;
    logic            alu_flag;
    logic            is_mul;
    ext_mode_t       mul_ext;
    logic [xlen-1:0] res_value;
    logic            res_flag;
    ext_mode_t       res_ext;
    logic            res_valid;

    assign op1 = issue_cmd.word ? {{(xlen-32){1'b0}}, issue_cmd.src1[31:0]}
                                : issue_cmd.src1;
    // word sra keeps bit 31 as the sign
    assign op1_sra = issue_cmd.word ? {{(xlen-32){issue_cmd.src1[31]}}, issue_cmd.src1[31:0]}
                                    : issue_cmd.src1;
    assign shamt = issue_cmd.word ? {1'b0, issue_cmd.src2[4:0]} : issue_cmd.src2[5:0];

    assign lt_s = $signed(issue_cmd.src1) < $signed(issue_cmd.src2);
    assign lt_u = issue_cmd.src1 < issue_cmd.src2;

    always_comb begin
        alu_val  = '0;
        alu_flag = 1'b0;
        case (issue_cmd.op)
            op_add:  alu_val = op1 + issue_cmd.src2;
            op_sub:  alu_val = op1 - issue_cmd.src2;
            op_and:  alu_val = issue_cmd.src1 & issue_cmd.src2;
            op_or:   alu_val = issue_cmd.src1 | issue_cmd.src2;
            op_xor:  alu_val = issue_cmd.src1 ^ issue_cmd.src2;
            op_sll:  alu_val = op1 << shamt;
            op_srl:  alu_val = op1 >> shamt;
            op_sra:  alu_val = $signed(op1_sra) >>> shamt;
            op_slt:  alu_val = {{(xlen-1){1'b0}}, lt_s};
            op_sltu: alu_val = {{(xlen-1){1'b0}}, lt_u};
            // compares only raise the flag
            op_beq:  alu_flag = issue_cmd.src1 == issue_cmd.src2;
            op_bne:  alu_flag = issue_cmd.src1 != issue_cmd.src2;
            op_blt:  alu_flag = lt_s;
            op_bge:  alu_flag = ~lt_s;
            op_bltu: alu_flag = lt_u;
            op_bgeu: alu_flag = ~lt_u;
            op_pass: alu_val = issue_cmd.src2;
            default: alu_val = '0;   // mul and unused codes
        endcase
    end

    assign is_mul    = issue_cmd.op == op_mul;
    assign mul_start = issue_valid & is_mul;
    assign mul_a     = issue_cmd.src1;
    assign mul_b     = issue_cmd.src2;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= (issue_valid & ~is_mul) | mul_done;
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_ext <= issue_cmd.ext;   // kept until the product arrives
        end
        if (mul_done) begin
            res_value <= mul_product;
            res_flag  <= 1'b0;
            res_ext   <= mul_ext;
        end else if (issue_valid && !is_mul) begin
            res_value <= alu_val;
            res_flag  <= alu_flag;
            res_ext   <= issue_cmd.ext;
        end
    end

    assign stage_out = '{value: res_value, flag: res_flag, ext: res_ext, valid: res_valid};

endmodule

`default_nettype wire

// ==== rvx_wb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module rvx_wb_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [2:0]               adr,
    input  logic [rvx_pkg::xlen-1:0] dat_w,
    output logic [rvx_pkg::xlen-1:0] dat_r,
    output logic                     ack,
    input  logic                     res_done,
    input  logic [rvx_pkg::xlen-1:0] final_value,
    input  logic                     final_flag,
    output rvx_pkg::exec_cmd_t       issue_cmd,
    output logic                     issue_valid
);
    import rvx_pkg::*;

    logic [xlen-1:0] src1_q;
    logic [xlen-1:0] src2_q;
    logic            served;     // this strobe already acked
    logic            busy;
    logic            done;
    logic            req;
    logic            cmd_write;
    logic            stall;
    logic            accept;

    assign req       = cyc & stb;
    assign cmd_write = we & (adr == reg_cmd);
    // a new command waits until the pipeline is idle
    assign stall     = cmd_write & busy;
    assign accept    = req & ~ack & ~served & ~stall;

    // single cycle ack, then nothing until stb drops
    always_ff @(posedge clk) begin
        if (reset) begin
            ack    <= 1'b0;
            served <= 1'b0;
        end else begin
            ack <= accept;
            if (!req) begin
                served <= 1'b0;
            end else if (ack) begin
                served <= 1'b1;
            end
        end
    end

    // operand registers
    always_ff @(posedge clk) begin
        if (accept && we) begin
            if (adr == reg_src1) begin
                src1_q <= dat_w;
            end
            if (adr == reg_src2) begin
                src2_q <= dat_w;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept & cmd_write;  // same cycle as ack
        end
    end

    // command word plus the stored operands
    always_ff @(posedge clk) begin
        if (accept && cmd_write) begin
            issue_cmd.op   <= alu_op_t'(dat_w[cmd_op_msb:cmd_op_lsb]);
            issue_cmd.word <= dat_w[cmd_word_bit];
            issue_cmd.ext  <= ext_mode_t'(dat_w[cmd_ext_msb:cmd_ext_lsb]);
            issue_cmd.src1 <= src1_q;
            issue_cmd.src2 <= src2_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (issue_valid) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (res_done) begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

    // reads never wait, data is valid while ack is high
    always_comb begin
        dat_r = '0;
        case (adr)
            reg_src1:   dat_r = src1_q;
            reg_src2:   dat_r = src2_q;
            reg_result: dat_r = final_value;
            reg_status: begin
                dat_r[stat_done_bit] = done;
                dat_r[stat_busy_bit] = busy;
                dat_r[stat_flag_bit] = final_flag;
            end
            default:    dat_r = '0;   // command word reads as zero
        endcase
    end

endmodule

`default_nettype wire

// ==== rvx_pkg.sv ====
`default_nettype none

package rvx_pkg;

    parameter int xlen = 64;

    // operation codes, command word bits 4..0
    typedef enum logic [4:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_and  = 5'd2,
        op_or   = 5'd3,
        op_xor  = 5'd4,
        op_sll  = 5'd5,
        op_srl  = 5'd6,
        op_sra  = 5'd7,
        op_slt  = 5'd8,
        op_sltu = 5'd9,
        op_beq  = 5'd10,
        op_bne  = 5'd11,
        op_blt  = 5'd12,
        op_bge  = 5'd13,
        op_bltu = 5'd14,
        op_bgeu = 5'd15,
        op_pass = 5'd16,   // move operand 2
        op_mul  = 5'd17    // iterative, low 64 bits
    } alu_op_t;

    typedef enum logic [1:0] {
        ext_none   = 2'd0,
        ext_sext32 = 2'd1,
        ext_zext32 = 2'd2,
        ext_sext16 = 2'd3
    } ext_mode_t;

    // one issued command
    typedef struct packed {
        alu_op_t         op;
        logic            word;   // 32-bit variant
        ext_mode_t       ext;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
    } exec_cmd_t;

    // execute to result stage
    typedef struct packed {
        logic [xlen-1:0] value;
        logic            flag;   // branch condition held
        ext_mode_t       ext;
        logic            valid;
    } stage_res_t;

    // word addresses
    localparam logic [2:0] reg_src1   = 3'd0;
    localparam logic [2:0] reg_src2   = 3'd1;
    localparam logic [2:0] reg_cmd    = 3'd2;
    localparam logic [2:0] reg_result = 3'd3;
    localparam logic [2:0] reg_status = 3'd4;

    // command word fields
    localparam int cmd_op_lsb   = 0;
    localparam int cmd_op_msb   = 4;
    localparam int cmd_word_bit = 5;
    localparam int cmd_ext_lsb  = 6;
    localparam int cmd_ext_msb  = 7;

    // status word bits
    localparam int stat_done_bit = 0;
    localparam int stat_busy_bit = 1;
    localparam int stat_flag_bit = 2;

endpackage

`default_nettype wire
